// ==== hdl/exc_pkg.sv ====
// exception encodings for the trap-entry path
// cause codes, handler selects and controller states
`default_nettype none

package exc_pkg;

  ////////////////////
  // cause codes
  ////////////////////

  // synchronous causes only
  // an interrupt cause has bit 5 set and the line index below it
  typedef enum logic [5:0] {
    CAUSE_ILLINSN   = 6'd2,
    CAUSE_LOAD_ERR  = 6'd5,
    CAUSE_STORE_ERR = 6'd7,
    CAUSE_ECALL     = 6'd8
  } cause_e;

  ////////////////////
  // handler select
  ////////////////////

  typedef enum logic [2:0] {
    SEL_ILLINSN,
    SEL_ECALL,
    SEL_LOAD,
    SEL_STORE,
    SEL_IRQ
  } pc_sel_e;

  // exception controller FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT_CONTROLLER,
    IN_ISR
  } exc_state_e;

endpackage

`default_nettype wire

// ==== hdl/trap_cfg_pkg.sv ====
// address layout of the trap-entry path
`default_nettype none

package trap_cfg_pkg;

  // program counter and handler address width
  parameter int unsigned ADDR_W = 32;

  // saved cause width, irq flag in the top bit
  parameter int unsigned CAUSE_W = 6;

  // level-triggered interrupt lines
  parameter int unsigned IRQ_NUM = 32;

  // handler table base, 256 byte aligned
  parameter logic [ADDR_W-1:0] VEC_BASE_DEFAULT = 32'h0000_0100;

endpackage

`default_nettype wire

// ==== hdl/exc_controller.sv ====
// exception controller
// picks a trap cause by priority and runs the req/ack/in-handler FSM
`default_nettype none

module exc_controller (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  // interrupt lines and enable
  input  wire logic [trap_cfg_pkg::IRQ_NUM-1:0]   irq_i,
  input  wire logic                               irq_enable_i,
  // decoder strobes
  input  wire logic                               illegal_insn_i,
  input  wire logic                               ecall_insn_i,
  input  wire logic                               eret_insn_i,
  // load-store unit strobes
  input  wire logic                               lsu_load_err_i,
  input  wire logic                               lsu_store_err_i,
  // handshake with entry controller
  input  wire logic                               ack_i,
  output logic                                    req_o,
  // to trap registers and target generator
  output logic                                    save_cause_o,
  output logic [trap_cfg_pkg::CAUSE_W-1:0]        cause_o,
  output exc_pkg::pc_sel_e                        pc_sel_o,
  output logic [4:0]                              vec_idx_o
);

  exc_pkg::exc_state_e               state_q, state_d;
  logic                              req_int;
  logic                              first_req;
  logic [trap_cfg_pkg::CAUSE_W-1:0]  cause_int, cause_q;
  exc_pkg::pc_sel_e                  pc_sel_int, pc_sel_q;
  logic [4:0]                        irq_idx;

  // any source pending, interrupts only when enabled
  assign req_int = illegal_insn_i | ecall_insn_i | lsu_load_err_i | lsu_store_err_i |
                   (irq_enable_i & (|irq_i));

  ////////////////////
  // cause selection
  ////////////////////

  // lowest set line wins
  always_comb begin
    irq_idx = '0;
    for (int i = trap_cfg_pkg::IRQ_NUM - 1; i >= 0; i--) begin
      if (irq_i[i]) begin
        irq_idx = 5'(i);
      end
    end
  end

  // later assignments override, so highest priority sits last
  always_comb begin
    cause_int  = '0;
    pc_sel_int = exc_pkg::SEL_ILLINSN;
    if (irq_enable_i && (|irq_i)) begin
      cause_int[trap_cfg_pkg::CAUSE_W-1] = 1'b1;
      cause_int[4:0]                     = irq_idx;
      pc_sel_int                         = exc_pkg::SEL_IRQ;
    end
    if (ecall_insn_i) begin
      cause_int  = exc_pkg::CAUSE_ECALL;
      pc_sel_int = exc_pkg::SEL_ECALL;
    end
    if (illegal_insn_i) begin
      cause_int  = exc_pkg::CAUSE_ILLINSN;
      pc_sel_int = exc_pkg::SEL_ILLINSN;
    end
    if (lsu_load_err_i) begin
      cause_int  = exc_pkg::CAUSE_LOAD_ERR;
      pc_sel_int = exc_pkg::SEL_LOAD;
    end
    if (lsu_store_err_i) begin
      cause_int  = exc_pkg::CAUSE_STORE_ERR;
      pc_sel_int = exc_pkg::SEL_STORE;
    end
  end

  // first request cycle, selection passes straight through
  assign first_req = (state_q == exc_pkg::IDLE) && req_int;

  // hold the selection until ack
  always_ff @(posedge clk) begin
    if (first_req) begin
      cause_q  <= cause_int;
      pc_sel_q <= pc_sel_int;
    end
  end

  assign cause_o   = first_req ? cause_int  : cause_q;
  assign pc_sel_o  = first_req ? pc_sel_int : pc_sel_q;
  // vector slot follows the irq index in the cause
  assign vec_idx_o = cause_o[4:0];

  ////////////////////
  // controller FSM
  ////////////////////

  always_comb begin
    state_d      = state_q;
    req_o        = 1'b0;
    save_cause_o = 1'b0;
    case (state_q)
      exc_pkg::IDLE: begin
        req_o = req_int;
        if (req_int) begin
          // ack may already be there on the first cycle
          state_d      = ack_i ? exc_pkg::IN_ISR : exc_pkg::WAIT_CONTROLLER;
          save_cause_o = ack_i;
        end
      end
      exc_pkg::WAIT_CONTROLLER: begin
        req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = exc_pkg::IN_ISR;
        end
      end
      exc_pkg::IN_ISR: begin
        // new sources ignored until return
        if (eret_insn_i) begin
          state_d = exc_pkg::IDLE;
        end
      end
      default: begin
        state_d = exc_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= exc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/exc_target_gen.sv ====
// handler address generator
// maps a handler select and vector index onto the handler table
`default_nettype none

module exc_target_gen #(
  parameter logic [trap_cfg_pkg::ADDR_W-1:0] VEC_BASE = trap_cfg_pkg::VEC_BASE_DEFAULT
) (
  input  wire exc_pkg::pc_sel_e              pc_sel_i,
  input  wire logic [4:0]                    vec_idx_i,
  output logic [trap_cfg_pkg::ADDR_W-1:0]    handler_addr_o
);

  // irq slots start above the synchronous handlers
  localparam logic [7:0] IRQ_OFFSET = 8'h40;

  logic [7:0] offset;

  ////////////////////
  // table offset
  ////////////////////

  always_comb begin
    case (pc_sel_i)
      exc_pkg::SEL_ILLINSN: offset = 8'h00;
      exc_pkg::SEL_ECALL:   offset = 8'h04;
      exc_pkg::SEL_LOAD:    offset = 8'h08;
      exc_pkg::SEL_STORE:   offset = 8'h0C;
      // one word per line, 0x40 up to 0xBC
      exc_pkg::SEL_IRQ:     offset = IRQ_OFFSET + {1'b0, vec_idx_i, 2'b00};
      default:              offset = 8'h00;
    endcase
  end

  // base is 256 byte aligned, offset fills the low byte
  assign handler_addr_o = {VEC_BASE[trap_cfg_pkg::ADDR_W-1:8], offset};

endmodule

`default_nettype wire

// ==== hdl/trap_entry_ctrl.sv ====
// trap entry controller, pipeline side
// acks requests when not stalled and issues the fetch redirect
`default_nettype none

module trap_entry_ctrl (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire logic                               req_i,
  input  wire logic                               stall_i,
  input  wire logic                               eret_insn_i,
  input  wire logic [trap_cfg_pkg::ADDR_W-1:0]    handler_addr_i,
  input  wire logic [trap_cfg_pkg::ADDR_W-1:0]    mepc_i,
  output logic                                    ack_o,
  output logic                                    redirect_o,
  output logic [trap_cfg_pkg::ADDR_W-1:0]         redirect_addr_o
);

  // stalled pipeline holds the request off
  assign ack_o = req_i & ~stall_i;

  ////////////////////
  // fetch redirect
  ////////////////////

  // single cycle pulse on entry or return
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      redirect_o <= 1'b0;
    end else begin
      redirect_o <= ack_o | eret_insn_i;
    end
  end

  // trap entry wins over a return in the same cycle
  always_ff @(posedge clk) begin
    if (ack_o) begin
      redirect_addr_o <= handler_addr_i;
    end else if (eret_insn_i) begin
      // back to the saved pc
      redirect_addr_o <= mepc_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/trap_csr.sv ====
// trap register block
// saved cause, return pc and global interrupt enable with pre-trap copy
`default_nettype none

module trap_csr (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  // trap entry
  input  wire logic                               save_cause_i,
  input  wire logic [trap_cfg_pkg::CAUSE_W-1:0]   cause_i,
  input  wire logic [trap_cfg_pkg::ADDR_W-1:0]    pc_i,
  // trap return
  input  wire logic                               eret_insn_i,
  // software write of the enable
  input  wire logic                               mie_we_i,
  input  wire logic                               mie_wdata_i,
  output logic [trap_cfg_pkg::CAUSE_W-1:0]        mcause_o,
  output logic [trap_cfg_pkg::ADDR_W-1:0]         mepc_o,
  output logic                                    irq_enable_o
);

  // enable as it was before the trap
  logic mie_prev_q;

  ////////////////////
  // cause and epc
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcause_o <= '0;
      mepc_o   <= '0;
    end else if (save_cause_i) begin
      mcause_o <= cause_i;
      mepc_o   <= pc_i;
    end
  end

  ////////////////////
  // interrupt enable
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_enable_o <= 1'b0;
      mie_prev_q   <= 1'b0;
    end else if (save_cause_i) begin
      // entry masks interrupts
      mie_prev_q   <= irq_enable_o;
      irq_enable_o <= 1'b0;
    end else if (eret_insn_i) begin
      irq_enable_o <= mie_prev_q;
    end else if (mie_we_i) begin
      irq_enable_o <= mie_wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/exc_unit.sv ====
// trap-entry subsystem top
// exception controller, target generator, entry controller and trap registers
`default_nettype none

module exc_unit #(
  parameter logic [trap_cfg_pkg::ADDR_W-1:0] VEC_BASE = trap_cfg_pkg::VEC_BASE_DEFAULT
) (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  // trap sources
  input  wire logic [trap_cfg_pkg::IRQ_NUM-1:0]   irq_i,
  input  wire logic                               illegal_insn_i,
  input  wire logic                               ecall_insn_i,
  input  wire logic                               eret_insn_i,
  input  wire logic                               lsu_load_err_i,
  input  wire logic                               lsu_store_err_i,
  // pipeline state
  input  wire logic                               stall_i,
  input  wire logic [trap_cfg_pkg::ADDR_W-1:0]    pc_i,
  // enable write
  input  wire logic                               mie_we_i,
  input  wire logic                               mie_wdata_i,
  // fetch redirect and trap registers
  output logic                                    redirect_o,
  output logic [trap_cfg_pkg::ADDR_W-1:0]         redirect_addr_o,
  output logic [trap_cfg_pkg::CAUSE_W-1:0]        mcause_o,
  output logic [trap_cfg_pkg::ADDR_W-1:0]         mepc_o,
  output logic                                    irq_enable_o
);

  logic                              req;
  logic                              ack;
  logic                              save_cause;
  logic [trap_cfg_pkg::CAUSE_W-1:0]  cause;
  exc_pkg::pc_sel_e                  pc_sel;
  logic [4:0]                        vec_idx;
  logic [trap_cfg_pkg::ADDR_W-1:0]   handler_addr;

  ////////////////////
  // cause and request
  ////////////////////

  exc_controller exc_controller_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .irq_i           (irq_i),
    .irq_enable_i    (irq_enable_o),
    .illegal_insn_i  (illegal_insn_i),
    .ecall_insn_i    (ecall_insn_i),
    .eret_insn_i     (eret_insn_i),
    .lsu_load_err_i  (lsu_load_err_i),
    .lsu_store_err_i (lsu_store_err_i),
    .ack_i           (ack),
    .req_o           (req),
    .save_cause_o    (save_cause),
    .cause_o         (cause),
    .pc_sel_o        (pc_sel),
    .vec_idx_o       (vec_idx)
  );

  exc_target_gen #(
    .VEC_BASE (VEC_BASE)
  ) exc_target_gen_i (
    .pc_sel_i       (pc_sel),
    .vec_idx_i      (vec_idx),
    .handler_addr_o (handler_addr)
  );

  ////////////////////
  // pipeline side
  ////////////////////

  trap_entry_ctrl trap_entry_ctrl_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req),
    .stall_i         (stall_i),
    .eret_insn_i     (eret_insn_i),
    .handler_addr_i  (handler_addr),
    .mepc_i          (mepc_o),
    .ack_o           (ack),
    .redirect_o      (redirect_o),
    .redirect_addr_o (redirect_addr_o)
  );

  trap_csr trap_csr_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .save_cause_i (save_cause),
    .cause_i      (cause),
    .pc_i         (pc_i),
    .eret_insn_i  (eret_insn_i),
    .mie_we_i     (mie_we_i),
    .mie_wdata_i  (mie_wdata_i),
    .mcause_o     (mcause_o),
    .mepc_o       (mepc_o),
    .irq_enable_o (irq_enable_o)
  );

endmodule

`default_nettype wire

// ==== test/exc_clk_gen.sv ====
// testbench clock and reset source
// free running clock, reset held low for a few cycles
`default_nettype none

module exc_clk_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/exc_unit_props.sv ====
// request path checks on the exception controller
// bound into exc_controller from the testbench
`default_nettype none

module exc_unit_props (
  input wire logic                              clk_i,
  input wire logic                              rst_n_i,
  input wire logic                              req_i,
  input wire logic                              ack_i,
  input wire logic                              save_cause_i,
  input wire logic [trap_cfg_pkg::CAUSE_W-1:0]  cause_i,
  input wire exc_pkg::exc_state_e               state_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // request held until the entry controller takes it
  req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && !ack_i) |=> req_i)
    else $error("req dropped before ack");

  // cause is saved only on the handshake cycle
  save_on_handshake: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    save_cause_i |-> (req_i && ack_i))
    else $error("save_cause without req and ack");

  // latched cause while waiting
  cause_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && !ack_i) |=> $stable(cause_i))
    else $error("cause changed while waiting for ack");

  // handler residence, sources ignored
  no_req_in_isr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_i == exc_pkg::IN_ISR) |-> !req_i)
    else $error("req raised in IN_ISR");

endmodule

`default_nettype wire

// ==== test/exc_unit_tb.sv ====
// testbench for the trap-entry subsystem
// vectors from a data file, checks redirects, trap registers and enable
`default_nettype none

module exc_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MAX_TESTS    = 64;
  localparam int unsigned FIELDS       = 8;
  localparam int unsigned MAX_STALL    = 8;
  localparam int unsigned RESET_CYCLES = 4;
  // one test without its stall, enable write to return pulse
  localparam int unsigned TEST_CYCLES  = 20;
  localparam int unsigned MARGIN       = 100;

  logic        clk;
  logic        rst_n;
  logic [31:0] irq;
  logic        illegal_insn;
  logic        ecall_insn;
  logic        eret_insn;
  logic        lsu_load_err;
  logic        lsu_store_err;
  logic        stall;
  logic [31:0] pc;
  logic        mie_we;
  logic        mie_wdata;
  logic        redirect;
  logic [31:0] redirect_addr;
  logic [5:0]  mcause;
  logic [31:0] mepc;
  logic        irq_enable;

  // kind src irq mie stall pc exp_addr exp_cause, one row per test
  logic [31:0] vec_mem [0:MAX_TESTS*FIELDS-1];
  int unsigned n_tests;
  int unsigned err_count   = 0;
  int unsigned n_failed    = 0;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 1000;

  exc_clk_gen #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (RESET_CYCLES)
  ) exc_clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  // handler table at 0x100, as the vector file expects
  exc_unit #(
    .VEC_BASE (32'h0000_0100)
  ) exc_unit_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .irq_i           (irq),
    .illegal_insn_i  (illegal_insn),
    .ecall_insn_i    (ecall_insn),
    .eret_insn_i     (eret_insn),
    .lsu_load_err_i  (lsu_load_err),
    .lsu_store_err_i (lsu_store_err),
    .stall_i         (stall),
    .pc_i            (pc),
    .mie_we_i        (mie_we),
    .mie_wdata_i     (mie_wdata),
    .redirect_o      (redirect),
    .redirect_addr_o (redirect_addr),
    .mcause_o        (mcause),
    .mepc_o          (mepc),
    .irq_enable_o    (irq_enable)
  );

  bind exc_controller exc_unit_props exc_unit_props_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req_o),
    .ack_i        (ack_i),
    .save_cause_i (save_cause_o),
    .cause_i      (cause_o),
    .state_i      (state_q)
  );

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // src bit 0 illegal, 1 ecall, 2 load error, 3 store error
  task automatic drive_sources(input logic [3:0] src, input logic [31:0] lines);
    illegal_insn  <= src[0];
    ecall_insn    <= src[1];
    lsu_load_err  <= src[2];
    lsu_store_err <= src[3];
    irq           <= lines;
  endtask

  task automatic clear_sources();
    drive_sources(4'b0000, 32'h0);
  endtask

  // write lands on the second edge
  task automatic write_enable(input logic value);
    @(posedge clk);
    mie_we    <= 1'b1;
    mie_wdata <= value;
    @(posedge clk);
    mie_we    <= 1'b0;
    @(negedge clk);
    check_value("enable after write", 32'(irq_enable), 32'(value));
  endtask

  // cycles counted from the drive edge
  task automatic wait_redirect(output int unsigned cycles);
    cycles = 0;
    @(negedge clk);
    while (!redirect) begin
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic trap_and_return(input int unsigned idx);
    int unsigned base;
    int unsigned stall_cycles;
    int unsigned cycles;
    logic        mie;
    logic [31:0] pc_val;
    logic [31:0] got_addr;
    logic [31:0] got_cause;
    logic [31:0] got_epc;
    logic        got_en;
    base = idx * FIELDS;
    mie  = vec_mem[base+3][0];
    // ff stall and zero pc are picked at random
    stall_cycles = (vec_mem[base+4] == 32'hff) ? 1 + ($urandom % MAX_STALL) : vec_mem[base+4];
    pc_val       = (vec_mem[base+5] == 32'h0) ? ($urandom & 32'hffff_fffc) : vec_mem[base+5];
    write_enable(mie);

    // trap entry
    @(posedge clk);
    drive_sources(vec_mem[base+1][3:0], vec_mem[base+2]);
    pc    <= pc_val;
    stall <= (stall_cycles > 0);
    fork
      begin
        @(posedge clk);
        clear_sources();
        if (stall_cycles > 0) begin
          // late store error must not replace the latched cause
          lsu_store_err <= 1'b1;
          repeat (stall_cycles - 1) @(posedge clk);
          stall <= 1'b0;
        end
        @(posedge clk);
        lsu_store_err <= 1'b0;
      end
      begin
        wait_redirect(cycles);
        got_addr  = redirect_addr;
        got_cause = 32'(mcause);
        got_epc   = mepc;
        got_en    = irq_enable;
      end
    join
    check_value("entry latency", cycles, stall_cycles + 1);
    check_value("handler address", got_addr, vec_mem[base+6]);
    check_value("mcause", got_cause, vec_mem[base+7]);
    check_value("mepc", got_epc, pc_val);
    check_value("enable in handler", 32'(got_en), 32'd0);
    @(negedge clk);
    check_value("entry redirect width", 32'(redirect), 32'd0);

    // sources inside the handler
    @(posedge clk);
    illegal_insn <= 1'b1;
    ecall_insn   <= 1'b1;
    @(posedge clk);
    clear_sources();
    repeat (3) begin
      @(negedge clk);
      check_value("redirect in handler", 32'(redirect), 32'd0);
    end

    // return
    @(posedge clk);
    eret_insn <= 1'b1;
    fork
      begin
        @(posedge clk);
        eret_insn <= 1'b0;
      end
      begin
        wait_redirect(cycles);
        got_addr  = redirect_addr;
        got_cause = 32'(mcause);
        got_epc   = mepc;
        got_en    = irq_enable;
      end
    join
    check_value("return latency", cycles, 32'd1);
    check_value("return address", got_addr, pc_val);
    check_value("mepc after return", got_epc, pc_val);
    check_value("mcause after return", got_cause, vec_mem[base+7]);
    check_value("enable after return", 32'(got_en), 32'(mie));
    @(negedge clk);
    check_value("return redirect width", 32'(redirect), 32'd0);
  endtask

  // interrupt lines with the enable clear
  task automatic masked_irq_check(input int unsigned idx);
    int unsigned base;
    base = idx * FIELDS;
    write_enable(vec_mem[base+3][0]);
    @(posedge clk);
    irq <= vec_mem[base+2];
    repeat (4) begin
      @(negedge clk);
      check_value("redirect while masked", 32'(redirect), 32'd0);
    end
    @(posedge clk);
    irq <= 32'h0;
  endtask

  ////////////////////
  // timeout
  ////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: no end of run after %0d cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int unsigned seed;
    int unsigned stall_max;
    int unsigned stall_len;
    int unsigned errs_before;
    irq          = 32'h0;
    illegal_insn = 1'b0;
    ecall_insn   = 1'b0;
    eret_insn    = 1'b0;
    lsu_load_err = 1'b0;
    lsu_store_err = 1'b0;
    stall        = 1'b0;
    pc           = 32'h0;
    mie_we       = 1'b0;
    mie_wdata    = 1'b0;
    seed         = $urandom(32'hf593);
    stall_max    = 0;
    n_tests      = 0;

    // unused rows read back as an invalid kind
    for (int i = 0; i < MAX_TESTS * FIELDS; i++) begin
      vec_mem[i] = 32'he000_0000 | 32'(i);
    end
    $readmemh("test/exc_input.txt", vec_mem);
    while (n_tests < MAX_TESTS && vec_mem[n_tests * FIELDS] < 32'd2) begin
      stall_len = vec_mem[n_tests * FIELDS + 4];
      if (stall_len == 32'hff) begin
        stall_len = MAX_STALL;
      end
      if (stall_len > stall_max) begin
        stall_max = stall_len;
      end
      n_tests++;
    end
    cycle_limit = RESET_CYCLES + n_tests * (TEST_CYCLES + stall_max) + MARGIN;

    if (n_tests == 0) begin
      $display("no test vectors found in test/exc_input.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      @(posedge rst_n);
      @(negedge clk);
      check_value("redirect after reset", 32'(redirect), 32'd0);
      check_value("mcause after reset", 32'(mcause), 32'd0);
      check_value("mepc after reset", mepc, 32'd0);
      check_value("enable after reset", 32'(irq_enable), 32'd0);
      $display("reset values checked, %0d errors", err_count);

      for (int unsigned t = 0; t < n_tests; t++) begin
        errs_before = err_count;
        if (vec_mem[t * FIELDS] == 32'd1) begin
          masked_irq_check(t);
        end else begin
          trap_and_return(t);
        end
        if (err_count == errs_before) begin
          $display("test %0d passed", t);
        end else begin
          n_failed++;
          $display("test %0d: %0d mismatches", t, err_count - errs_before);
        end
      end

      $display("%0d tests run, %0d failed, %0d mismatches", n_tests, n_failed, err_count);
      if (err_count == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/exc_input.txt ====
// kind src irq mie stall pc exp_addr exp_cause, all hex, handler base 0x100
// kind 0 trap and return, 1 masked irq; src bits illegal ecall load store; stall ff and pc 0 random
0 1 00000000 1 00 00001000 00000100 00000002
0 2 00000000 1 00 00001004 00000104 00000008
0 4 00000000 1 00 00000000 00000108 00000005
0 8 00000000 0 00 00000000 0000010c 00000007
// priority between sources
0 9 00000000 1 00 00000000 0000010c 00000007
0 2 00000010 1 00 00000000 00000104 00000008
0 6 00000000 1 00 00000000 00000108 00000005
0 3 00000000 0 00 00000000 00000100 00000002
// vectored interrupts, lowest line wins
0 0 00000001 1 00 00000000 00000140 00000020
0 0 00000a00 1 00 00003000 00000164 00000029
0 0 80000000 1 00 00000000 000001bc 0000003f
// enable clear
1 0 00000004 0 00 00000000 00000000 00000000
0 1 00000004 0 00 00000000 00000100 00000002
1 0 ffffffff 0 00 00000000 00000000 00000000
// entry under stall
0 2 00000000 1 ff 00000000 00000104 00000008
0 1 00000000 0 ff 00000000 00000100 00000002
0 0 00000100 1 ff 00000000 00000160 00000028
0 4 00000000 1 03 00002000 00000108 00000005
0 8 00000000 1 ff 00000000 0000010c 00000007
0 0 00000006 1 ff 00000000 00000144 00000021

// ==== exc_unit.f ====
hdl/exc_pkg.sv
hdl/trap_cfg_pkg.sv
hdl/exc_controller.sv
hdl/exc_target_gen.sv
hdl/trap_entry_ctrl.sv
hdl/trap_csr.sv
hdl/exc_unit.sv
test/exc_clk_gen.sv
test/exc_unit_props.sv
test/exc_unit_tb.sv

// ==== Makefile ====
# Verilator flow for the trap-entry subsystem

VERILATOR  ?= verilator
TOP        ?= exc_unit_tb
FILELIST   ?= exc_unit.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= TEST FAILED
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
